// File: build.f
+incdir+common
common/rv32m_pkg.sv
logic/rv32m_decode.sv
logic/rv32m_control.sv
rv32m_execute/rv32m_multiplier.sv
rv32m_execute/rv32m_divider.sv
logic/rv32m_unit.sv
verif/rv32m_checker.sv
verif/tb_rv32m.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the rv32m testbench with Verilator and runs it
# exit status is zero only when the run prints the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_rv32m \
  -f build.f \
  -o sim_rv32m

output=$(./obj_dir/sim_rv32m)
echo "$output"

if echo "$output" | grep -qx 'RESULT: PASS'; then
  exit 0
else
  exit 1
fi

// File: verif/tb_rv32m.sv
// testbench top for the rv32m unit
// random M-extension and foreign instruction words from a fixed seed,
// a host register file model that feeds operands and takes results,
// rv32m_checker beside the DUT does the comparing

`default_nettype none

`include "rv32m_cfg.svh"

module tb_rv32m;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS = 200;
  // one full hold behind a busy unit per test, plus slack
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (`RV32M_LATENCY + 4) + 200;

  logic                    CLK;
  logic                    rst_n;
  rv32m_pkg::word_t        insn;
  logic                    insn_valid;
  rv32m_pkg::word_t        rdata_s_0;
  rv32m_pkg::word_t        rdata_s_1;
  logic                    insn_claim;
  rv32m_pkg::reg_sel_set_t rsel;
  logic                    busy;
  logic                    done;
  rv32m_pkg::result_t      result;
  rv32m_pkg::word_t        regs [32];
  integer                  seed;
  int                      test_count;
  int                      pass_count;
  int                      error_count;

  always #5 CLK = ~CLK;

  rv32m_unit UUT (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .insn       (insn),
    .insn_valid (insn_valid),
    .rdata_s_0  (rdata_s_0),
    .rdata_s_1  (rdata_s_1),
    .insn_claim (insn_claim),
    .rsel       (rsel),
    .busy       (busy),
    .done       (done),
    .result     (result)
  );

  rv32m_checker u_checker (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .insn        (insn),
    .insn_valid  (insn_valid),
    .rdata_s_0   (rdata_s_0),
    .rdata_s_1   (rdata_s_1),
    .insn_claim  (insn_claim),
    .rsel        (rsel),
    .busy        (busy),
    .done        (done),
    .result      (result),
    .test_count  (test_count),
    .pass_count  (pass_count),
    .error_count (error_count)
  );

  // host write-back, x0 stays zero
  always @(posedge CLK) begin
    #1;
    if (done && result.rd != 5'd0) begin
      regs[result.rd] = result.value;
    end
  end

  function automatic rv32m_pkg::word_t corner_value(input logic [1:0] sel);
    rv32m_pkg::word_t v;
    case (sel)
      2'd0:    v = '0;
      2'd1:    v = 32'h0000_0001;
      2'd2:    v = '1;
      default: v = 32'h8000_0000;
    endcase
    return v;
  endfunction

  // random R-type word, mostly M ops
  task automatic make_insn(output rv32m_pkg::word_t w, output logic is_m);
    rv32m_pkg::rv32m_insn_t f;
    logic [31:0]            r;
    logic [31:0]            k;
    r = $random(seed);
    k = $random(seed);
    f.opcode_major = `RV32M_OPCODE;
    f.opcode_minor = `RV32M_OPCODE_MINOR;
    f.funct        = r[2:0];
    f.rd           = r[7:3];
    f.rs1          = r[12:8];
    f.rs2          = r[17:13];
    is_m           = 1'b1;
    // one in eight with a foreign major opcode, one in eight with foreign funct7
    if (k[2:0] == 3'd0) begin
      f.opcode_major = (r[24:18] == `RV32M_OPCODE) ? 7'h13 : r[24:18];
      is_m           = 1'b0;
    end else if (k[2:0] == 3'd1) begin
      f.opcode_minor = (r[31:25] == `RV32M_OPCODE_MINOR) ? 7'h20 : r[31:25];
      is_m           = 1'b0;
    end
    // corner operand in about one of four sources
    if (k[4:3] == 2'd0 && f.rs1 != 5'd0) begin
      regs[f.rs1] = corner_value(k[6:5]);
    end
    if (k[8:7] == 2'd0 && f.rs2 != 5'd0) begin
      regs[f.rs2] = corner_value(k[10:9]);
    end
    w = f;
  endtask

  // register file read through the DUT selects
  task automatic load_operands;
    rdata_s_0 = regs[rsel.rsel_s_0];
    rdata_s_1 = regs[rsel.rsel_s_1];
  endtask

  // entered and left 2 ns after a rising edge
  task automatic run_test;
    rv32m_pkg::word_t w;
    logic             is_m;
    logic             taken;
    make_insn(w, is_m);
    insn       = w;
    insn_valid = 1'b1;
    #1;
    load_operands();
    if (is_m) begin
      taken = 1'b0;
      // hold until an edge with busy low takes it
      while (!taken) begin
        @(negedge CLK);
        taken = insn_claim && !busy;
        @(posedge CLK);
        #2;
        if (!taken) begin
          #1;
          load_operands();
        end
      end
    end else begin
      repeat (3) begin
        @(posedge CLK);
        #2;
      end
      // withdraw for one cycle
      insn_valid = 1'b0;
      @(posedge CLK);
      #2;
    end
  endtask

  initial begin
    seed       = 68397;
    CLK        = 1'b0;
    rst_n      = 1'b0;
    insn       = '0;
    insn_valid = 1'b0;
    rdata_s_0  = '0;
    rdata_s_1  = '0;
    regs[0]    = '0;
    for (int i = 1; i < 32; i++) begin
      regs[i] = $random(seed);
    end
    repeat (5) @(posedge CLK);
    #2;
    rst_n = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test();
    end
    insn_valid = 1'b0;
    // drain the last operation
    @(negedge CLK);
    while (busy || done) begin
      @(negedge CLK);
    end
    repeat (2) @(negedge CLK);
    $display("tests %0d of %0d, passed %0d, errors %0d",
             test_count, NUM_TESTS, pass_count, error_count);
    if (error_count == 0 && test_count == NUM_TESTS) begin
      $display("RESULT: PASS");
    end else begin
      if (test_count != NUM_TESTS) begin
        $display("not every test reached completion");
      end
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("watchdog expired, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/rv32m_checker.sv
// checker beside the rv32m DUT
// samples the ports on the falling edge, where they are stable,
// predicts each accepted operation from the RISC-V M rules,
// checks claim, selects, latency and the completion record

`default_nettype none

`include "rv32m_cfg.svh"

module rv32m_checker (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  rv32m_pkg::word_t        insn,
  input  logic                    insn_valid,
  input  rv32m_pkg::word_t        rdata_s_0,
  input  rv32m_pkg::word_t        rdata_s_1,
  input  logic                    insn_claim,
  input  rv32m_pkg::reg_sel_set_t rsel,
  input  logic                    busy,
  input  logic                    done,
  input  rv32m_pkg::result_t      result,
  output int                      test_count,
  output int                      pass_count,
  output int                      error_count
);
  timeunit 1ns;
  timeprecision 100ps;

  rv32m_pkg::rv32m_insn_t f;
  logic                   exp_claim;
  // operation in flight
  logic                   pending;
  logic                   cur_ok;
  int                     cyc;
  int                     next_id;
  int                     cur_id;
  rv32m_pkg::funct_t      cur_funct;
  rv32m_pkg::reg_sel_t    cur_rd;
  rv32m_pkg::word_t       cur_a;
  rv32m_pkg::word_t       cur_b;
  rv32m_pkg::word_t       cur_exp;
  logic                   prev_valid;
  logic                   prev_claim;

  // reference results, 64-bit arithmetic and ISA corner rules
  function automatic rv32m_pkg::word_t model_result(input rv32m_pkg::funct_t fn,
                                                    input rv32m_pkg::word_t a,
                                                    input rv32m_pkg::word_t b);
    logic [63:0]        sa;
    logic [63:0]        ua;
    logic [63:0]        sb;
    logic [63:0]        ub;
    logic [63:0]        p;
    logic signed [31:0] qa;
    logic signed [31:0] qb;
    rv32m_pkg::word_t   v;
    logic               ovf;
    sa  = {{32{a[31]}}, a};
    ua  = {32'b0, a};
    sb  = {{32{b[31]}}, b};
    ub  = {32'b0, b};
    qa  = a;
    qb  = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    p   = '0;
    case (fn)
      3'd0: begin
        p = sa * sb;
        v = p[31:0];
      end
      3'd1: begin
        p = sa * sb;
        v = p[63:32];
      end
      3'd2: begin
        p = sa * ub;
        v = p[63:32];
      end
      3'd3: begin
        p = ua * ub;
        v = p[63:32];
      end
      // truncating division, remainder follows the dividend
      3'd4: begin
        if (b == '0) begin
          v = '1;
        end else if (ovf) begin
          v = a;
        end else begin
          // both operands signed here
          v = qa / qb;
        end
      end
      3'd5: v = (b == '0) ? '1 : a / b;
      3'd6: begin
        if (b == '0) begin
          v = a;
        end else if (ovf) begin
          v = '0;
        end else begin
          v = qa % qb;
        end
      end
      default: v = (b == '0) ? a : a % b;
    endcase
    return v;
  endfunction

  function automatic string op_name(input rv32m_pkg::funct_t fn);
    string s;
    case (fn)
      3'd0:    s = "MUL";
      3'd1:    s = "MULH";
      3'd2:    s = "MULHSU";
      3'd3:    s = "MULHU";
      3'd4:    s = "DIV";
      3'd5:    s = "DIVU";
      3'd6:    s = "REM";
      default: s = "REMU";
    endcase
    return s;
  endfunction

  task automatic report_fault(input string msg);
    $display("%s", msg);
    error_count++;
    cur_ok = 1'b0;
  endtask

  initial begin
    test_count  = 0;
    pass_count  = 0;
    error_count = 0;
    next_id     = 0;
    pending     = 1'b0;
    cyc         = 0;
    prev_valid  = 1'b0;
    prev_claim  = 1'b0;
  end

  always @(negedge CLK) begin
    f         = rv32m_pkg::rv32m_insn_t'(insn);
    exp_claim = (f.opcode_major == `RV32M_OPCODE) && (f.opcode_minor == `RV32M_OPCODE_MINOR);
    if (!rst_n) begin
      if (busy || done) begin
        report_fault("busy or done high while reset is asserted");
      end
      pending    = 1'b0;
      prev_valid = 1'b0;
      prev_claim = 1'b0;
    end else begin
      if (pending) begin
        cyc++;
        if (cyc < `RV32M_LATENCY) begin
          if (done) begin
            report_fault($sformatf("test %0d %s: done came %0d cycles after acceptance",
                                   cur_id, op_name(cur_funct), cyc));
          end
          if (!busy) begin
            report_fault($sformatf("test %0d %s: busy dropped while the operation was running",
                                   cur_id, op_name(cur_funct)));
          end
        end else begin
          pending = 1'b0;
          test_count++;
          if (!done) begin
            report_fault($sformatf("test %0d %s: no done %0d cycles after acceptance",
                                   cur_id, op_name(cur_funct), cyc));
          end else begin
            if (result.value !== cur_exp) begin
              $display("error test %0d %s value expected %h actual %h",
                       cur_id, op_name(cur_funct), cur_exp, result.value);
              error_count++;
              cur_ok = 1'b0;
            end
            if (result.rd !== cur_rd) begin
              $display("error test %0d %s rd expected %0d actual %0d",
                       cur_id, op_name(cur_funct), cur_rd, result.rd);
              error_count++;
              cur_ok = 1'b0;
            end
          end
          if (cur_ok) begin
            pass_count++;
            $display("test %0d %s %h, %h -> x%0d = %h pass",
                     cur_id, op_name(cur_funct), cur_a, cur_b, cur_rd, result.value);
          end
        end
      end else begin
        if (done) begin
          report_fault("done high with no accepted request behind it");
        end
        if (busy) begin
          report_fault("busy high with no operation in flight");
        end
      end
      // claim and selects are combinational from insn
      if (insn_valid) begin
        if (insn_claim !== exp_claim) begin
          $display("error claim of %h expected %b actual %b", insn, exp_claim, insn_claim);
          error_count++;
        end
        if (rsel !== {f.rs1, f.rs2, f.rd}) begin
          $display("error rsel of %h expected %h actual %h", insn, {f.rs1, f.rs2, f.rd}, rsel);
          error_count++;
        end
      end
      // foreign word withdrawn without being taken
      if (prev_valid && !prev_claim && !insn_valid) begin
        next_id++;
        test_count++;
        pass_count++;
        $display("test %0d unclaimed word %h left alone pass", next_id, insn);
      end
      // accepted on the coming rising edge
      if (insn_valid && insn_claim && !busy) begin
        next_id++;
        cur_id    = next_id;
        cur_funct = f.funct;
        cur_rd    = f.rd;
        cur_a     = rdata_s_0;
        cur_b     = rdata_s_1;
        cur_exp   = model_result(f.funct, rdata_s_0, rdata_s_1);
        cur_ok    = 1'b1;
        pending   = 1'b1;
        // counts edges after the accepting one, which is still ahead
        cyc       = -1;
      end
      prev_valid = insn_valid;
      prev_claim = insn_claim;
    end
  end

endmodule

`default_nettype wire

// File: logic/rv32m_unit.sv
// top level of the rv32m unit
// host presents an instruction word with a valid level and the two
// source operands; claim and register selects come back at once,
// the result returns with a one-cycle done pulse
// a held request waits while busy is high

`default_nettype none

module rv32m_unit (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  rv32m_pkg::word_t        insn,
  input  logic                    insn_valid,
  input  rv32m_pkg::word_t        rdata_s_0,
  input  rv32m_pkg::word_t        rdata_s_1,
  output logic                    insn_claim,
  output rv32m_pkg::reg_sel_set_t rsel,
  output logic                    busy,
  output logic                    done,
  output rv32m_pkg::result_t      result
);

  rv32m_pkg::decode_execute_t idex;
  rv32m_pkg::word_t           op_a;
  rv32m_pkg::word_t           op_b;
  rv32m_pkg::dword_t          product;
  rv32m_pkg::word_t           quotient;
  rv32m_pkg::word_t           remainder;
  logic                       signed_a;
  logic                       signed_b;
  logic                       mul_load;
  logic                       div_load;
  logic                       step;

  rv32m_decode u_decode (
    .insn       (insn),
    .idex       (idex),
    .insn_claim (insn_claim),
    .rsel       (rsel)
  );

  rv32m_control u_control (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .insn_valid (insn_valid),
    .insn_claim (insn_claim),
    .idex       (idex),
    .rd         (rsel.rsel_d),
    .rdata_s_0  (rdata_s_0),
    .rdata_s_1  (rdata_s_1),
    .product    (product),
    .quotient   (quotient),
    .remainder  (remainder),
    .op_a       (op_a),
    .op_b       (op_b),
    .signed_a   (signed_a),
    .signed_b   (signed_b),
    .mul_load   (mul_load),
    .div_load   (div_load),
    .step       (step),
    .busy       (busy),
    .done       (done),
    .result     (result)
  );

  rv32m_multiplier u_multiplier (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .load     (mul_load),
    .step     (step),
    .op_a     (op_a),
    .op_b     (op_b),
    .signed_a (signed_a),
    .signed_b (signed_b),
    .product  (product)
  );

  // divide ops are signed on both sides or on neither
  rv32m_divider u_divider (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .load       (div_load),
    .step       (step),
    .op_a       (op_a),
    .op_b       (op_b),
    .signed_ops (signed_a),
    .quotient   (quotient),
    .remainder  (remainder)
  );

endmodule

`default_nettype wire

// File: rv32m_execute/rv32m_divider.sv
// iterative restoring divider for DIV, DIVU, REM and REMU
// works on operand magnitudes, one quotient bit per step,
// then applies the signs: quotient gets the xor of both signs,
// remainder gets the sign of the dividend
// divide by zero yields all ones and the dividend, as the ISA wants;
// signed overflow comes out as most negative with remainder zero

`default_nettype none

`include "rv32m_cfg.svh"

module rv32m_divider (
  input  logic             CLK,
  input  logic             rst_n,
  input  logic             load,
  input  logic             step,
  input  rv32m_pkg::word_t op_a,
  input  rv32m_pkg::word_t op_b,
  input  logic             signed_ops,
  output rv32m_pkg::word_t quotient,
  output rv32m_pkg::word_t remainder
);

  rv32m_pkg::word_t      divisor;
  rv32m_pkg::word_t      quo;
  rv32m_pkg::word_t      rem;
  rv32m_pkg::word_t      mag_a;
  rv32m_pkg::word_t      mag_b;
  logic [`RV32M_XLEN:0]  rem_shift;
  logic [`RV32M_XLEN:0]  trial;
  logic                  neg_a;
  logic                  neg_b;
  logic                  neg_quo;
  logic                  neg_rem;
  logic                  div_zero;

  assign neg_a = signed_ops && op_a[`RV32M_XLEN-1];
  assign neg_b = signed_ops && op_b[`RV32M_XLEN-1];
  assign mag_a = neg_a ? -op_a : op_a;
  assign mag_b = neg_b ? -op_b : op_b;

  // partial remainder shifted left with the next dividend bit
  assign rem_shift = {rem, quo[`RV32M_XLEN-1]};
  // 33-bit trial subtract, msb set means it went negative
  assign trial     = rem_shift - {1'b0, divisor};

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      divisor  <= '0;
      quo      <= '0;
      rem      <= '0;
      neg_quo  <= 1'b0;
      neg_rem  <= 1'b0;
      div_zero <= 1'b0;
    end else if (load) begin
      // dividend enters through the quotient register
      divisor  <= mag_b;
      quo      <= mag_a;
      rem      <= '0;
      neg_quo  <= neg_a ^ neg_b;
      neg_rem  <= neg_a;
      div_zero <= op_b == '0;
    end else if (step) begin
      if (!trial[`RV32M_XLEN]) begin
        // fits, keep the difference
        rem <= trial[`RV32M_XLEN-1:0];
        quo <= {quo[`RV32M_XLEN-2:0], 1'b1};
      end else begin
        // restore
        rem <= rem_shift[`RV32M_XLEN-1:0];
        quo <= {quo[`RV32M_XLEN-2:0], 1'b0};
      end
    end
  end

  // zero divisor leaves quo all ones; must not be negated
  assign quotient  = (neg_quo && !div_zero) ? -quo : quo;
  // zero divisor leaves |dividend| here, sign fix restores the dividend
  assign remainder = neg_rem ? -rem : rem;

endmodule

`default_nettype wire

// File: rv32m_execute/rv32m_multiplier.sv
// iterative shift-add multiplier, 32x32 to 64 bits
// load captures operand magnitudes and the product sign, each step
// adds the shifted multiplicand for one multiplier bit
// product holds once stepping stops

`default_nettype none

`include "rv32m_cfg.svh"

module rv32m_multiplier (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              load,
  input  logic              step,
  input  rv32m_pkg::word_t  op_a,
  input  rv32m_pkg::word_t  op_b,
  input  logic              signed_a,
  input  logic              signed_b,
  output rv32m_pkg::dword_t product
);

  rv32m_pkg::dword_t mcand;
  rv32m_pkg::dword_t acc;
  rv32m_pkg::word_t  mplier;
  rv32m_pkg::word_t  mag_a;
  rv32m_pkg::word_t  mag_b;
  logic              neg_a;
  logic              neg_b;
  logic              negate;

  // operand sign only counts for a signed operand
  assign neg_a = signed_a && op_a[`RV32M_XLEN-1];
  assign neg_b = signed_b && op_b[`RV32M_XLEN-1];

  // magnitudes, most negative maps to 2^31 which still fits unsigned
  assign mag_a = neg_a ? -op_a : op_a;
  assign mag_b = neg_b ? -op_b : op_b;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mcand  <= '0;
      mplier <= '0;
      acc    <= '0;
      negate <= 1'b0;
    end else if (load) begin
      // multiplicand widened to 64 bits for the left shifts
      mcand  <= {{`RV32M_XLEN{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
      negate <= neg_a ^ neg_b;
    end else if (step) begin
      // lsb of multiplier decides the add
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // apply sign to the unsigned accumulation
  assign product = negate ? -acc : acc;

  // control only pulses load outside run
  a_load_step_excl: assert property (@(posedge CLK) disable iff (!rst_n)
    !(load && step));

endmodule

`default_nettype wire

// File: logic/rv32m_control.sv
// sequencer of the rv32m unit
// accepts a claimed request while idle, latches operands and the
// decode record, pulses load to one execute unit, steps both for
// the fixed count, then picks and registers the result with done
// done rises RV32M_LATENCY cycles after the accepting edge

`default_nettype none

`include "rv32m_cfg.svh"

module rv32m_control (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic                       insn_valid,
  input  logic                       insn_claim,
  input  rv32m_pkg::decode_execute_t idex,
  input  rv32m_pkg::reg_sel_t        rd,
  input  rv32m_pkg::word_t           rdata_s_0,
  input  rv32m_pkg::word_t           rdata_s_1,
  input  rv32m_pkg::dword_t          product,
  input  rv32m_pkg::word_t           quotient,
  input  rv32m_pkg::word_t           remainder,
  output rv32m_pkg::word_t           op_a,
  output rv32m_pkg::word_t           op_b,
  output logic                       signed_a,
  output logic                       signed_b,
  output logic                       mul_load,
  output logic                       div_load,
  output logic                       step,
  output logic                       busy,
  output logic                       done,
  output rv32m_pkg::result_t         result
);

  localparam int CNT_W = $clog2(`RV32M_STEPS);

  rv32m_pkg::ctrl_state_t     state;
  rv32m_pkg::ctrl_state_t     state_next;
  logic [CNT_W-1:0]           step_cnt;
  logic                       last_step;
  logic                       accept;
  rv32m_pkg::decode_execute_t op_rec;
  rv32m_pkg::reg_sel_t        op_rd;
  rv32m_pkg::word_t           value_sel;

  // only an idle unit takes a request
  assign accept    = insn_valid && insn_claim && (state == rv32m_pkg::idle);
  assign last_step = step_cnt == CNT_W'(`RV32M_STEPS - 1);

  always_comb begin
    state_next = state;
    case (state)
      rv32m_pkg::idle:   if (accept) state_next = rv32m_pkg::load;
      rv32m_pkg::load:   state_next = rv32m_pkg::run;
      // one step per cycle, leave after the last
      rv32m_pkg::run:    if (last_step) state_next = rv32m_pkg::finish;
      rv32m_pkg::finish: state_next = rv32m_pkg::idle;
      default:           state_next = rv32m_pkg::idle;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rv32m_pkg::idle;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      state <= state_next;
      // counter restarts in load, advances in run
      if (state == rv32m_pkg::load) begin
        step_cnt <= '0;
      end else if (state == rv32m_pkg::run) begin
        step_cnt <= step_cnt + 1'b1;
      end
      done <= state == rv32m_pkg::finish;
    end
  end

  // operands and record captured at the accepting edge
  always_ff @(posedge CLK) begin
    if (accept) begin
      op_a   <= rdata_s_0;
      op_b   <= rdata_s_1;
      op_rec <= idex;
      op_rd  <= rd;
    end
  end

  // dividend side is signed unless both are unsigned
  assign signed_a = ~op_rec.usign_usign;
  assign signed_b = op_rec.sign_sign;

  // load goes only to the unit that owns the operation
  assign mul_load = (state == rv32m_pkg::load) && op_rec.mul;
  assign div_load = (state == rv32m_pkg::load) && !op_rec.mul;
  assign step     = state == rv32m_pkg::run;
  // drops together with the rise of done
  assign busy     = state != rv32m_pkg::idle;

  // result pick
  always_comb begin
    if (op_rec.mul) begin
      value_sel = op_rec.lower_word ? product[`RV32M_XLEN-1:0]
                                    : product[2*`RV32M_XLEN-1:`RV32M_XLEN];
    end else if (op_rec.div) begin
      value_sel = quotient;
    end else begin
      value_sel = remainder;
    end
  end

  always_ff @(posedge CLK) begin
    if (state == rv32m_pkg::finish) begin
      result.rd    <= op_rd;
      result.value <= value_sel;
    end
  end

  // latched record behind a load names one class and one signedness pair
  a_rec_wellformed: assert property (@(posedge CLK) disable iff (!rst_n)
    (state == rv32m_pkg::load) |->
      op_rec.start && $onehot({op_rec.mul, op_rec.div, op_rec.rem}) &&
      $onehot({op_rec.usign_usign, op_rec.sign_sign, op_rec.sign_usign}));

  // completion is a single-cycle pulse
  a_done_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
    done |=> !done);

endmodule

`default_nettype wire

// File: logic/rv32m_decode.sv
// combinational decoder for the RV32M instructions
// claims a word when major opcode and funct7 match, hands out the
// register selects and turns funct into the operation class,
// the operand signedness pair and the low/high product choice

`default_nettype none

`include "rv32m_cfg.svh"

module rv32m_decode #(
  parameter rv32m_pkg::opcode_t OPCODE = `RV32M_OPCODE
) (
  input  rv32m_pkg::word_t          insn,
  output rv32m_pkg::decode_execute_t idex,
  output logic                      insn_claim,
  output rv32m_pkg::reg_sel_set_t   rsel
);

  rv32m_pkg::rv32m_insn_t fields;

  // reinterpret the raw word
  assign fields = rv32m_pkg::rv32m_insn_t'(insn);

  // both opcode fields must match
  assign insn_claim = (fields.opcode_major == OPCODE) &&
                      (fields.opcode_minor == `RV32M_OPCODE_MINOR);

  // selects follow the fields even for unclaimed words
  assign rsel.rsel_s_0 = fields.rs1;
  assign rsel.rsel_s_1 = fields.rs2;
  assign rsel.rsel_d   = fields.rd;

  assign idex.start = insn_claim;

  // funct[2] clear is a multiply, then funct[1] splits div from rem
  assign idex.mul = ~fields.funct[2];
  assign idex.div = fields.funct[2:1] == 2'b10;
  assign idex.rem = fields.funct[2:1] == 2'b11;

  // MULHU, DIVU, REMU
  assign idex.usign_usign = (fields.funct == 3'b011) || (fields.funct == 3'b101) ||
                            (fields.funct == 3'b111);
  // MUL, MULH, DIV, REM
  assign idex.sign_sign   = (fields.funct == 3'b000) || (fields.funct == 3'b001) ||
                            (fields.funct == 3'b100) || (fields.funct == 3'b110);
  // MULHSU only
  assign idex.sign_usign  = fields.funct == 3'b010;

  // only meaningful with mul set
  assign idex.lower_word = ~(|fields.funct[1:0]);

endmodule

`default_nettype wire

// File: common/rv32m_pkg.sv
// shared types of the rv32m unit
// words, selectors, the instruction view, the decode record,
// the completion record and the control state encoding
// referenced everywhere as rv32m_pkg::name

`default_nettype none

`include "rv32m_cfg.svh"

package rv32m_pkg;

  // data words
  typedef logic [`RV32M_XLEN-1:0]   word_t;
  typedef logic [2*`RV32M_XLEN-1:0] dword_t;

  // instruction fields
  typedef logic [4:0] reg_sel_t;
  typedef logic [2:0] funct_t;
  typedef logic [6:0] opcode_t;

  // R-type layout, msb first
  typedef struct packed {
    opcode_t  opcode_minor;
    reg_sel_t rs2;
    reg_sel_t rs1;
    funct_t   funct;
    reg_sel_t rd;
    opcode_t  opcode_major;
  } rv32m_insn_t;

  // decode to execute record
  typedef struct packed {
    logic start;
    logic mul;
    logic div;
    logic rem;
    logic usign_usign;
    logic sign_sign;
    logic sign_usign;
    // mul only: low half of the product
    logic lower_word;
  } decode_execute_t;

  // register selects toward the host register file
  typedef struct packed {
    reg_sel_t rsel_s_0;
    reg_sel_t rsel_s_1;
    reg_sel_t rsel_d;
  } reg_sel_set_t;

  // completion record, valid with done
  typedef struct packed {
    reg_sel_t rd;
    word_t    value;
  } result_t;

  // control sequencing
  typedef enum logic [1:0] {
    idle,
    load,
    run,
    finish
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: common/rv32m_cfg.svh
// configuration macros for the rv32m multiply/divide unit
// include this before any module or package that needs widths, opcodes
// or the fixed step count; the guard makes repeated inclusion harmless

`ifndef RV32M_CFG_SVH
`define RV32M_CFG_SVH

// data word width
`define RV32M_XLEN 32

// major opcode of register-register operations (OP)
`define RV32M_OPCODE 7'b0110011

// funct7 value marking the M extension
`define RV32M_OPCODE_MINOR 7'b0000001

// iteration steps per operation, one result bit per step
`define RV32M_STEPS `RV32M_XLEN

// accepting edge to done pulse: load + steps + finish
`define RV32M_LATENCY (`RV32M_STEPS + 2)

`endif
